// ==== rv64_exec_cfg.svh ====
// ----------------------------
// RV64 execute slice widths.
// Data, word and ALU control sizes
// shared by the package and the RTL.
// ----------------------------

`ifndef RV64_EXEC_CFG_SVH
`define RV64_EXEC_CFG_SVH

// Architectural register width.
`define RV64_XLEN 64

// Width of the *W operations.
`define RV64_WLEN 32

// ALU operation code width.
`define RV64_CTRL_W 5

`endif

// ==== rv64_exec_pkg.sv ====
// ----------------------------
// RV64 execute slice package.
// ALU operation codes, major opcodes and
// the two views of an instruction word.
// ----------------------------

`include "rv64_exec_cfg.svh"

package rv64_exec_pkg;

    // ----------------------------
    // ALU operations.
    // ----------------------------
    // Codes 15 to 18 are unused.
    typedef enum logic [`RV64_CTRL_W-1:0] {
        ALU_ADD  = 0,
        ALU_SUB  = 1,
        ALU_AND  = 2,
        ALU_OR   = 3,
        ALU_XOR  = 4,
        ALU_SLL  = 5,
        ALU_SLT  = 6,
        ALU_SLTU = 7,
        ALU_SRL  = 8,
        ALU_SRA  = 9,
        ALU_ADDW = 10,
        ALU_SUBW = 11,
        ALU_SLLW = 12,
        ALU_SRLW = 13,
        ALU_SRAW = 14,
        ALU_DIVW = 19,
        ALU_MULW = 20
    } alu_op_t;

    // ----------------------------
    // Major opcodes.
    // ----------------------------
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;

    // ----------------------------
    // Instruction word views.
    // ----------------------------
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

endpackage

// ==== rv64_decoder.sv ====
// ----------------------------
// RV64 instruction decoder.
// Maps OP, OP-IMM, OP-32 and OP-IMM-32 words
// to an ALU operation and its operands.
// Unmatched encodings are flagged illegal.
// ----------------------------

`timescale 1ns/10ps

`include "rv64_exec_cfg.svh"

module rv64_decoder
    import rv64_exec_pkg::*;
(
    input  instr_u                 i_instr,
    input  logic [`RV64_XLEN-1:0]  i_rs1_data,
    input  logic [`RV64_XLEN-1:0]  i_rs2_data,
    output alu_op_t                o_alu_op,
    output logic [`RV64_XLEN-1:0]  o_op_a,
    output logic [`RV64_XLEN-1:0]  o_op_b,
    output logic [4:0]             o_rd,
    output logic                   o_illegal
);

    // funct7 classes.
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;
    localparam logic [6:0] F7_MDIV = 7'b0000001;

    logic [`RV64_XLEN-1:0] imm_sext;

    // I-type immediate, sign-extended to XLEN.
    assign imm_sext = {{(`RV64_XLEN-12){i_instr.i.imm[11]}}, i_instr.i.imm};

    always_comb begin
        o_alu_op  = ALU_ADD;
        o_op_a    = i_rs1_data;
        o_op_b    = i_rs2_data;
        o_rd      = i_instr.r.rd;
        o_illegal = 1'b0;

        case (i_instr.r.opcode)
            OPC_OP: begin
                case ({i_instr.r.funct7, i_instr.r.funct3})
                    {F7_BASE, 3'b000}: o_alu_op = ALU_ADD;
                    {F7_ALT,  3'b000}: o_alu_op = ALU_SUB;
                    {F7_BASE, 3'b001}: o_alu_op = ALU_SLL;
                    {F7_BASE, 3'b010}: o_alu_op = ALU_SLT;
                    {F7_BASE, 3'b011}: o_alu_op = ALU_SLTU;
                    {F7_BASE, 3'b100}: o_alu_op = ALU_XOR;
                    {F7_BASE, 3'b101}: o_alu_op = ALU_SRL;
                    {F7_ALT,  3'b101}: o_alu_op = ALU_SRA;
                    {F7_BASE, 3'b110}: o_alu_op = ALU_OR;
                    {F7_BASE, 3'b111}: o_alu_op = ALU_AND;
                    default:           o_illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                o_op_b = imm_sext;
                case (i_instr.i.funct3)
                    3'b000: o_alu_op = ALU_ADD;
                    3'b010: o_alu_op = ALU_SLT;
                    3'b011: o_alu_op = ALU_SLTU;
                    3'b100: o_alu_op = ALU_XOR;
                    3'b110: o_alu_op = ALU_OR;
                    3'b111: o_alu_op = ALU_AND;
                    3'b001: begin
                        o_alu_op  = ALU_SLL;
                        o_illegal = (i_instr.i.imm[11:6] != 6'd0);
                    end
                    default: begin
                        // Imm bit 10 picks arithmetic over logical shift.
                        if (i_instr.i.imm[10]) o_alu_op = ALU_SRA;
                        else                   o_alu_op = ALU_SRL;
                        o_illegal = i_instr.i.imm[11] | (i_instr.i.imm[9:6] != 4'd0);
                    end
                endcase
            end
            OPC_OP_32: begin
                case ({i_instr.r.funct7, i_instr.r.funct3})
                    {F7_BASE, 3'b000}: o_alu_op = ALU_ADDW;
                    {F7_ALT,  3'b000}: o_alu_op = ALU_SUBW;
                    {F7_BASE, 3'b001}: o_alu_op = ALU_SLLW;
                    {F7_BASE, 3'b101}: o_alu_op = ALU_SRLW;
                    {F7_ALT,  3'b101}: o_alu_op = ALU_SRAW;
                    {F7_MDIV, 3'b000}: o_alu_op = ALU_MULW;
                    {F7_MDIV, 3'b100}: o_alu_op = ALU_DIVW;
                    default:           o_illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM_32: begin
                o_op_b = imm_sext;
                case (i_instr.i.funct3)
                    3'b000: o_alu_op = ALU_ADDW;
                    3'b001: begin
                        o_alu_op  = ALU_SLLW;
                        o_illegal = (i_instr.i.imm[11:5] != 7'd0);
                    end
                    3'b101: begin
                        if (i_instr.i.imm[10]) o_alu_op = ALU_SRAW;
                        else                   o_alu_op = ALU_SRLW;
                        o_illegal = i_instr.i.imm[11] | (i_instr.i.imm[9:5] != 5'd0);
                    end
                    default: o_illegal = 1'b1;
                endcase
            end
            default: o_illegal = 1'b1;
        endcase
    end

endmodule

// ==== rv64_issue_reg.sv ====
// ----------------------------
// Issue register.
// Holds one decoded operation between
// decode and execute for a single cycle.
// ----------------------------

`timescale 1ns/10ps

`include "rv64_exec_cfg.svh"

module rv64_issue_reg
    import rv64_exec_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_valid,
    input  alu_op_t                i_alu_op,
    input  logic [`RV64_XLEN-1:0]  i_op_a,
    input  logic [`RV64_XLEN-1:0]  i_op_b,
    input  logic [4:0]             i_rd,
    input  logic                   i_illegal,
    output logic                   o_valid,
    output alu_op_t                o_alu_op,
    output logic [`RV64_XLEN-1:0]  o_op_a,
    output logic [`RV64_XLEN-1:0]  o_op_b,
    output logic [4:0]             o_rd,
    output logic                   o_illegal
);

    // Valid strobe.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // Payload, loaded only for a valid item.
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_alu_op  <= i_alu_op;
            o_op_a    <= i_op_a;
            o_op_b    <= i_op_b;
            o_rd      <= i_rd;
            o_illegal <= i_illegal;
        end
    end

endmodule

// ==== rv64_alu.sv ====
// ----------------------------
// RV64 integer ALU.
// 64-bit and word operations, MULW and DIVW,
// plus zero and compare flags.
// ----------------------------

`timescale 1ns/10ps

`include "rv64_exec_cfg.svh"

module rv64_alu
    import rv64_exec_pkg::*;
(
    input  alu_op_t                i_alu_op,
    input  logic [`RV64_XLEN-1:0]  i_src_1,
    input  logic [`RV64_XLEN-1:0]  i_src_2,
    output logic [`RV64_XLEN-1:0]  o_alu_result,
    output logic                   o_zero_flag,
    output logic                   o_slt_flag,
    output logic                   o_sltu_flag
);

    localparam int SEXT_W = `RV64_XLEN - `RV64_WLEN;

    logic [`RV64_XLEN-1:0] sub_out;
    logic [`RV64_XLEN-1:0] sra_out;
    logic                  less_than;
    logic                  less_than_u;
    logic [`RV64_WLEN-1:0] src_1_w;
    logic [`RV64_WLEN-1:0] src_2_w;
    logic [`RV64_WLEN-1:0] subw_out;
    logic [`RV64_WLEN-1:0] sraw_out;
    logic [`RV64_WLEN-1:0] mulw_out;
    logic [`RV64_WLEN-1:0] divw_out;
    logic                  div_by_zero;
    logic                  div_overflow;

    // Sign-extend a word result to XLEN.
    function automatic logic [`RV64_XLEN-1:0] sext_w(input logic [`RV64_WLEN-1:0] w);
        sext_w = {{SEXT_W{w[`RV64_WLEN-1]}}, w};
    endfunction

    assign src_1_w = i_src_1[`RV64_WLEN-1:0];
    assign src_2_w = i_src_2[`RV64_WLEN-1:0];

    // ----------------------------
    // Datapath.
    // ----------------------------
    assign sub_out     = i_src_1 - i_src_2;
    assign sra_out     = $signed(i_src_1) >>> i_src_2[5:0];
    assign less_than   = $signed(i_src_1) < $signed(i_src_2);
    assign less_than_u = i_src_1 < i_src_2;

    assign subw_out = src_1_w - src_2_w;
    assign sraw_out = $signed(src_1_w) >>> i_src_2[4:0];
    // Low half of the product does not depend on signedness.
    assign mulw_out = src_1_w * src_2_w;

    // DIVW corner cases from the ISA.
    assign div_by_zero  = (src_2_w == '0);
    assign div_overflow = (src_1_w == {1'b1, {(`RV64_WLEN-1){1'b0}}}) && (src_2_w == '1);

    always_comb begin
        if (div_by_zero) begin
            divw_out = '1;
        end else if (div_overflow) begin
            divw_out = src_1_w;
        end else begin
            divw_out = $signed(src_1_w) / $signed(src_2_w);
        end
    end

    // ----------------------------
    // Result select.
    // ----------------------------
    always_comb begin
        o_alu_result = '0;
        case (i_alu_op)
            ALU_ADD:  o_alu_result = i_src_1 + i_src_2;
            ALU_SUB:  o_alu_result = sub_out;
            ALU_AND:  o_alu_result = i_src_1 & i_src_2;
            ALU_OR:   o_alu_result = i_src_1 | i_src_2;
            ALU_XOR:  o_alu_result = i_src_1 ^ i_src_2;
            ALU_SLL:  o_alu_result = i_src_1 << i_src_2[5:0];
            ALU_SLT:  o_alu_result = {{(`RV64_XLEN-1){1'b0}}, less_than};
            ALU_SLTU: o_alu_result = {{(`RV64_XLEN-1){1'b0}}, less_than_u};
            ALU_SRL:  o_alu_result = i_src_1 >> i_src_2[5:0];
            ALU_SRA:  o_alu_result = sra_out;
            ALU_ADDW: o_alu_result = sext_w(src_1_w + src_2_w);
            ALU_SUBW: o_alu_result = sext_w(subw_out);
            ALU_SLLW: o_alu_result = sext_w(src_1_w << i_src_2[4:0]);
            ALU_SRLW: o_alu_result = sext_w(src_1_w >> i_src_2[4:0]);
            ALU_SRAW: o_alu_result = sext_w(sraw_out);
            ALU_MULW: o_alu_result = sext_w(mulw_out);
            ALU_DIVW: o_alu_result = sext_w(divw_out);
            default:  o_alu_result = '0;
        endcase
    end

    // Flags.
    assign o_zero_flag = ~|o_alu_result;
    assign o_slt_flag  = less_than;
    assign o_sltu_flag = less_than_u;

endmodule

// ==== rv64_execute.sv ====
// ----------------------------
// Execute unit.
// Runs the ALU on the issued operation and
// registers result, destination and flags.
// ----------------------------

`timescale 1ns/10ps

`include "rv64_exec_cfg.svh"

module rv64_execute
    import rv64_exec_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_valid,
    input  alu_op_t                i_alu_op,
    input  logic [`RV64_XLEN-1:0]  i_op_a,
    input  logic [`RV64_XLEN-1:0]  i_op_b,
    input  logic [4:0]             i_rd,
    input  logic                   i_illegal,
    output logic                   o_valid,
    output logic [`RV64_XLEN-1:0]  o_result,
    output logic [4:0]             o_rd,
    output logic                   o_zero,
    output logic                   o_slt,
    output logic                   o_sltu,
    output logic                   o_illegal
);

    logic [`RV64_XLEN-1:0] alu_result;
    logic                  alu_zero;
    logic                  alu_slt;
    logic                  alu_sltu;

    rv64_alu u_alu (
        .i_alu_op     (i_alu_op),
        .i_src_1      (i_op_a),
        .i_src_2      (i_op_b),
        .o_alu_result (alu_result),
        .o_zero_flag  (alu_zero),
        .o_slt_flag   (alu_slt),
        .o_sltu_flag  (alu_sltu)
    );

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // Illegal items retire with a zero result and rd.
    // Zero flag then tracks the forced result.
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_result  <= i_illegal ? '0 : alu_result;
            o_rd      <= i_illegal ? 5'd0 : i_rd;
            o_zero    <= i_illegal | alu_zero;
            o_slt     <= alu_slt;
            o_sltu    <= alu_sltu;
            o_illegal <= i_illegal;
        end
    end

endmodule

// ==== rv64_exec_top.sv ====
// ----------------------------
// RV64 execute slice top.
// Decoder, issue register and execute unit.
// ----------------------------

`timescale 1ns/10ps

`include "rv64_exec_cfg.svh"

module rv64_exec_top
    import rv64_exec_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_valid,
    input  logic [31:0]            i_instr,
    input  logic [`RV64_XLEN-1:0]  i_rs1_data,
    input  logic [`RV64_XLEN-1:0]  i_rs2_data,
    output logic                   o_valid,
    output logic [`RV64_XLEN-1:0]  o_result,
    output logic [4:0]             o_rd,
    output logic                   o_zero,
    output logic                   o_slt,
    output logic                   o_sltu,
    output logic                   o_illegal
);

    // Decode stage.
    alu_op_t               dec_alu_op;
    logic [`RV64_XLEN-1:0] dec_op_a;
    logic [`RV64_XLEN-1:0] dec_op_b;
    logic [4:0]            dec_rd;
    logic                  dec_illegal;

    // Issue stage.
    logic                  iss_valid;
    alu_op_t               iss_alu_op;
    logic [`RV64_XLEN-1:0] iss_op_a;
    logic [`RV64_XLEN-1:0] iss_op_b;
    logic [4:0]            iss_rd;
    logic                  iss_illegal;

    rv64_decoder u_decoder (
        .i_instr    (i_instr),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .o_alu_op   (dec_alu_op),
        .o_op_a     (dec_op_a),
        .o_op_b     (dec_op_b),
        .o_rd       (dec_rd),
        .o_illegal  (dec_illegal)
    );

    rv64_issue_reg u_issue_reg (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_valid   (i_valid),
        .i_alu_op  (dec_alu_op),
        .i_op_a    (dec_op_a),
        .i_op_b    (dec_op_b),
        .i_rd      (dec_rd),
        .i_illegal (dec_illegal),
        .o_valid   (iss_valid),
        .o_alu_op  (iss_alu_op),
        .o_op_a    (iss_op_a),
        .o_op_b    (iss_op_b),
        .o_rd      (iss_rd),
        .o_illegal (iss_illegal)
    );

    rv64_execute u_execute (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_valid   (iss_valid),
        .i_alu_op  (iss_alu_op),
        .i_op_a    (iss_op_a),
        .i_op_b    (iss_op_b),
        .i_rd      (iss_rd),
        .i_illegal (iss_illegal),
        .o_valid   (o_valid),
        .o_result  (o_result),
        .o_rd      (o_rd),
        .o_zero    (o_zero),
        .o_slt     (o_slt),
        .o_sltu    (o_sltu),
        .o_illegal (o_illegal)
    );

endmodule

// ==== rv64_exec_sva.sv ====
// ----------------------------
// Execute slice assertions.
// Reset, latency and illegal-result rules
// checked at the top level.
// ----------------------------

`timescale 1ns/10ps

`include "rv64_exec_cfg.svh"

module rv64_exec_sva (
    input logic                  i_clk,
    input logic                  i_reset,
    input logic                  i_valid,
    input logic                  o_valid,
    input logic                  o_illegal,
    input logic [`RV64_XLEN-1:0] o_result
);

    // Output strobe is cleared by reset.
    a_reset_clears: assert property (@(posedge i_clk) i_reset |=> !o_valid)
        else $error("o_valid high in the cycle after reset");

    // Two register stages between input and output.
    a_latency: assert property (@(posedge i_clk)
        !i_reset && !$past(i_reset) && !$past(i_reset, 2) |-> o_valid == $past(i_valid, 2))
        else $error("o_valid does not follow i_valid by two cycles");

    // Illegal items retire with a zero result.
    a_illegal_zero: assert property (@(posedge i_clk) disable iff (i_reset)
        o_valid && o_illegal |-> o_result == '0)
        else $error("o_result not zero for an illegal instruction");

endmodule

// ==== tb_rv64_exec.sv ====
// ----------------------------
// Testbench for the RV64 execute slice.
// Random and directed OP, OP-IMM, OP-32 and
// OP-IMM-32 words checked against a reference.
// ----------------------------

`timescale 1ns/10ps

`include "rv64_exec_cfg.svh"

module tb_rv64_exec
    import rv64_exec_pkg::*;
();

    localparam int N_RAND  = 300;
    localparam int N_WORD  = 200;
    localparam int N_DIV   = 6;
    localparam int N_ILL   = 10;
    localparam int N_TESTS = N_RAND + N_WORD + N_DIV + N_ILL;

    logic                  i_clk;
    logic                  i_reset;
    logic                  i_valid;
    logic [31:0]           i_instr;
    logic [`RV64_XLEN-1:0] i_rs1_data;
    logic [`RV64_XLEN-1:0] i_rs2_data;
    logic                  o_valid;
    logic [`RV64_XLEN-1:0] o_result;
    logic [4:0]            o_rd;
    logic                  o_zero;
    logic                  o_slt;
    logic                  o_sltu;
    logic                  o_illegal;

    logic [31:0] lfsr;
    logic [72:0] exp_q[$];
    int          cyc_q[$];
    int          cycle_cnt = 0;
    int          errors = 0;
    int          checks = 0;
    int          n_sent = 0;

    rv64_exec_top dut0 (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .o_valid    (o_valid),
        .o_result   (o_result),
        .o_rd       (o_rd),
        .o_zero     (o_zero),
        .o_slt      (o_slt),
        .o_sltu     (o_sltu),
        .o_illegal  (o_illegal)
    );

    bind rv64_exec_top rv64_exec_sva sva0 (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_valid   (i_valid),
        .o_valid   (o_valid),
        .o_illegal (o_illegal),
        .o_result  (o_result)
    );

    initial i_clk = 1'b0;
    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) cycle_cnt <= cycle_cnt + 1;

    // Galois LFSR, one step per bit.
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [31:0] make_r(input logic [31:0] r, input logic [6:0] f7,
                                           input logic [2:0] f3, input logic [6:0] opc);
        instr_u u;
        u          = r;
        u.r.funct7 = f7;
        u.r.funct3 = f3;
        u.r.opcode = opc;
        return u;
    endfunction

    function automatic logic [31:0] make_i(input logic [31:0] r, input logic [2:0] f3,
                                           input logic [6:0] opc);
        instr_u u;
        u          = r;
        u.i.funct3 = f3;
        u.i.opcode = opc;
        // Shift immediates keep the shamt and the arithmetic bit.
        if (f3 == 3'd1 || f3 == 3'd5) begin
            u.i.imm[11]  = 1'b0;
            u.i.imm[9:6] = 4'd0;
            if (f3 == 3'd1) u.i.imm[10] = 1'b0;
            if (opc == OPC_OP_IMM_32) u.i.imm[5] = 1'b0;
        end
        return u;
    endfunction

    // Expected {illegal, sltu, slt, zero, rd, result} from the ISA rules.
    function automatic logic [72:0] ref_exec(input logic [31:0] w, input logic [63:0] a,
                                             input logic [63:0] rs2);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [63:0] b;
        logic [63:0] res;
        logic [31:0] aw;
        logic [31:0] bw;
        logic [31:0] rw;
        logic [4:0]  rd;
        logic        bad;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        rd  = w[11:7];
        bad = 1'b0;
        rw  = '0;
        res = '0;
        b   = rs2;
        if (opc == OPC_OP_IMM || opc == OPC_OP_IMM_32) b = {{52{w[31]}}, w[31:20]};
        aw = a[31:0];
        bw = b[31:0];
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                if (opc == OPC_OP)
                    bad = f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                else if (f3 == 3'd1)
                    bad = w[31:26] != 6'h00;
                else if (f3 == 3'd5)
                    bad = w[31:26] != 6'h00 && w[31:26] != 6'h10;
                case (f3)
                    3'd0: res = (opc == OPC_OP && f7[5]) ? a - b : a + b;
                    3'd1: res = a << b[5:0];
                    3'd2: res = {63'd0, $signed(a) < $signed(b)};
                    3'd3: res = {63'd0, a < b};
                    3'd4: res = a ^ b;
                    3'd5: begin
                        if (w[30]) res = $signed(a) >>> b[5:0];
                        else       res = a >> b[5:0];
                    end
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
            end
            OPC_OP_32, OPC_OP_IMM_32: begin
                if (opc == OPC_OP_32)
                    bad = !(f7 == 7'h00 && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5))
                       && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))
                       && !(f7 == 7'h01 && (f3 == 3'd0 || f3 == 3'd4));
                else
                    bad = f3 != 3'd0 && !(f3 == 3'd1 && f7 == 7'h00)
                       && !(f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
                case (f3)
                    3'd0: begin
                        if (opc == OPC_OP_32 && f7 == 7'h01)      rw = aw * bw;
                        else if (opc == OPC_OP_32 && f7 == 7'h20) rw = aw - bw;
                        else                                      rw = aw + bw;
                    end
                    3'd1: rw = aw << bw[4:0];
                    3'd4: begin
                        // Divide by zero and signed overflow per the M extension.
                        if (bw == 32'd0)                                   rw = 32'hffff_ffff;
                        else if (aw == 32'h8000_0000 && bw == 32'hffff_ffff) rw = aw;
                        else                                               rw = $signed(aw) / $signed(bw);
                    end
                    3'd5: begin
                        if (w[30]) rw = $signed(aw) >>> bw[4:0];
                        else       rw = aw >> bw[4:0];
                    end
                    default: rw = '0;
                endcase
                res = {{32{rw[31]}}, rw};
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            res = '0;
            rd  = 5'd0;
        end
        return {bad, a >= b ? 1'b0 : 1'b1, $signed(a) < $signed(b), res == 64'd0, rd, res};
    endfunction

    function automatic logic [31:0] illegal_word(input int k, input logic [31:0] r);
        case (k)
            0: return make_r(r, 7'h01, 3'd0, OPC_OP);
            1: return make_r(r, 7'h20, 3'd1, OPC_OP);
            2: return make_r(r, 7'h00, 3'd2, OPC_OP_32);
            3: return make_r(r, 7'h01, 3'd5, OPC_OP_32);
            4: return make_r(r, 7'h00, 3'd2, OPC_OP_IMM_32);
            5: return make_r(r, 7'h01, 3'd1, OPC_OP_IMM_32);
            6: return make_r(r, 7'h30, 3'd5, OPC_OP_IMM);
            7: return make_r(r, 7'h00, 3'd0, 7'b0000011);
            8: return make_r(r, 7'h00, 3'd0, 7'b1100011);
            default: return make_r(r, 7'h00, 3'd0, 7'b1110011);
        endcase
    endfunction

    task automatic send(input logic [31:0] w, input logic [63:0] a, input logic [63:0] b);
        @(negedge i_clk);
        i_valid    = 1'b1;
        i_instr    = w;
        i_rs1_data = a;
        i_rs2_data = b;
        exp_q.push_back(ref_exec(w, a, b));
        // Issue and execute registers load on the next two edges.
        cyc_q.push_back(cycle_cnt + 2);
        n_sent++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge i_clk);
            i_valid = 1'b0;
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    // ----------------------------
    // Output comparison.
    // ----------------------------
    always @(negedge i_clk) begin : compare_outputs
        logic [72:0] e;
        int          c;
        if (o_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("error t=%0t o_valid raised with no instruction in flight", $time);
            end else begin
                e = exp_q.pop_front();
                c = cyc_q.pop_front();
                check_val("o_valid cycle", 64'(cycle_cnt), 64'(c));
                check_val("o_result", o_result, e[63:0]);
                check_val("o_rd", {59'd0, o_rd}, {59'd0, e[68:64]});
                check_val("o_zero", {63'd0, o_zero}, {63'd0, e[69]});
                check_val("o_illegal", {63'd0, o_illegal}, {63'd0, e[72]});
                // Compare flags carry no meaning for illegal items.
                if (!e[72]) begin
                    check_val("o_slt", {63'd0, o_slt}, {63'd0, e[70]});
                    check_val("o_sltu", {63'd0, o_sltu}, {63'd0, e[71]});
                end
            end
        end
    end

    // ----------------------------
    // Stimulus.
    // ----------------------------
    initial begin : stimulus
        logic [63:0] r;
        logic [63:0] a;
        logic [63:0] b;
        logic [31:0] w;
        logic [2:0]  f3;
        lfsr       = 32'h4004_3608;
        i_reset    = 1'b1;
        i_valid    = 1'b0;
        i_instr    = '0;
        i_rs1_data = '0;
        i_rs2_data = '0;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        idle(4);

        // Random OP and OP-IMM, back to back.
        for (int k = 0; k < N_RAND; k++) begin
            r  = rand_bits(32);
            a  = rand_bits(64);
            b  = rand_bits(64);
            f3 = r[14:12];
            if (r[0])
                w = make_r(r[31:0], (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                           f3, OPC_OP);
            else
                w = make_i(r[31:0], f3, OPC_OP_IMM);
            send(w, a, b);
        end

        // Random word forms.
        for (int k = 0; k < N_WORD; k++) begin
            r = rand_bits(32);
            a = rand_bits(64);
            b = rand_bits(64);
            if (r[1]) begin
                case (r[14:12])
                    3'd0:    w = make_r(r[31:0], 7'h00, 3'd0, OPC_OP_32);
                    3'd1:    w = make_r(r[31:0], 7'h20, 3'd0, OPC_OP_32);
                    3'd2:    w = make_r(r[31:0], 7'h00, 3'd1, OPC_OP_32);
                    3'd3:    w = make_r(r[31:0], 7'h00, 3'd5, OPC_OP_32);
                    3'd4:    w = make_r(r[31:0], 7'h20, 3'd5, OPC_OP_32);
                    3'd5:    w = make_r(r[31:0], 7'h01, 3'd0, OPC_OP_32);
                    default: w = make_r(r[31:0], 7'h01, 3'd4, OPC_OP_32);
                endcase
            end else begin
                f3 = r[13] ? 3'd5 : (r[12] ? 3'd1 : 3'd0);
                w  = make_i(r[31:0], f3, OPC_OP_IMM_32);
            end
            send(w, a, b);
        end

        // DIVW corner cases.
        r = rand_bits(32);
        w = make_r(r[31:0], 7'h01, 3'd4, OPC_OP_32);
        send(w, 64'h0000_0000_1234_5678, 64'h0);
        send(w, 64'hffff_ffff_8000_0000, 64'hffff_ffff_ffff_ffff);
        send(w, 64'h5a5a_5a5a_8000_0000, 64'h0000_0000_ffff_ffff);
        send(w, 64'h0000_0000_0000_0007, 64'hffff_ffff_ffff_fffe);
        send(w, 64'hffff_ffff_ffff_fff9, 64'h0000_0000_0000_0002);
        send(w, 64'h0, 64'hffff_ffff_0000_0000);

        // Unknown opcodes and funct codes.
        for (int k = 0; k < N_ILL; k++) begin
            r = rand_bits(32);
            a = rand_bits(64);
            send(illegal_word(k, r[31:0]), a, ~a);
        end

        idle(4);
        while (exp_q.size() != 0) @(negedge i_clk);
        idle(2);
        $display("sent %0d checks %0d errors %0d", n_sent, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Watchdog.
    initial begin
        #((N_TESTS + 20) * 100);
        $display("timeout, outputs still missing after %0d of %0d tests", n_sent, N_TESTS);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== rv64_exec.f ====
+incdir+.
rv64_exec_pkg.sv
rv64_decoder.sv
rv64_issue_reg.sv
rv64_alu.sv
rv64_execute.sv
rv64_exec_top.sv
rv64_exec_sva.sv
tb_rv64_exec.sv

// ==== Makefile ====
TOP = tb_rv64_exec

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f rv64_exec.f

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f rv64_exec.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^\*\* PASS \*\*$$'

clean:
	rm -rf obj_dir
